//--- common/memPkg.sv
package memPkg;

    // data path widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strobe_t;
    typedef logic [1:0]  byteOff_t;

    // lane operation and access size
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } memOp_e;

    typedef enum logic [1:0] {
        SIZE1,
        SIZE2,
        SIZE4
    } memSize_e;

    // MIPS Cause.ExcCode values for address errors
    typedef enum logic [4:0] {
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5
    } excCode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_DONE
    } stageState_e;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apbState_e;

    // kseg0 and kseg1 both start with 2'b10
    localparam logic [1:0] KSEG_TOP = 2'b10;

    // data RAM geometry and wait state generator
    localparam int RAM_WORDS    = 256;
    localparam int RAM_IDX_W    = $clog2(RAM_WORDS);
    localparam int RAM_MAX_WAIT = 2;
    localparam int WAIT_W       = $clog2(RAM_MAX_WAIT + 1);

    typedef logic [RAM_IDX_W-1:0] ramIndex_t;
    typedef logic [WAIT_W-1:0]    waitCnt_t;
    typedef logic [7:0]           lfsr_t;

    localparam lfsr_t LFSR_SEED = 8'hA5;

endpackage

//--- common/dataReqIf.sv
`timescale 1ns/10ps

interface dataReqIf
    import memPkg::*;
();

    logic    valid;
    logic    write;
    addr_t   paddr;
    word_t   wdata;
    strobe_t strobe;
    logic    done;
    word_t   rdata;

    // request side, held stable until done
    modport lane (
        output valid, write, paddr, wdata, strobe,
        input  done, rdata
    );

    // done is a single cycle pulse with rdata
    modport arb (
        input  valid, write, paddr, wdata, strobe,
        output done, rdata
    );

endinterface

//--- memStage/byteLaneAlign.sv
`timescale 1ns/10ps

module byteLaneAlign
    import memPkg::*;
(
    input  byteOff_t addrLow,
    input  memSize_e size,
    input  logic     isSigned,
    input  word_t    storeData,
    input  word_t    loadWord,
    output word_t    alignedData,
    output strobe_t  strobe,
    output logic     misaligned,
    output word_t    loadData
);

    word_t shifted;

    // addressed bytes moved down to bit 0
    assign shifted = loadWord >> {addrLow, 3'b000};

    always_comb begin
        case (size)
            SIZE1: begin
                misaligned  = 1'b0;
                alignedData = {4{storeData[7:0]}};
                strobe      = strobe_t'(4'b0001) << addrLow;
                loadData    = {{24{isSigned & shifted[7]}}, shifted[7:0]};
            end
            SIZE2: begin
                misaligned  = addrLow[0];
                alignedData = {2{storeData[15:0]}};
                strobe      = strobe_t'(4'b0011) << {addrLow[1], 1'b0};
                loadData    = {{16{isSigned & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                misaligned  = |addrLow;
                alignedData = storeData;
                strobe      = 4'b1111;
                loadData    = shifted;
            end
        endcase
    end

endmodule

//--- memStage/memStage.sv
`timescale 1ns/10ps

module memStage
    import memPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        inValid,
    output logic        inReady,
    input  memOp_e      lane1Op,
    input  memSize_e    lane1Size,
    input  logic        lane1Signed,
    input  addr_t       lane1Vaddr,
    input  word_t       lane1Wdata,
    input  memOp_e      lane0Op,
    input  memSize_e    lane0Size,
    input  logic        lane0Signed,
    input  addr_t       lane0Vaddr,
    input  word_t       lane0Wdata,
    output logic        outValid,
    output word_t       lane1Rdata,
    output word_t       lane0Rdata,
    output logic        excValid,
    output logic        excLane,
    output excCode_e    excCode,
    output addr_t       badVaddr,
    dataReqIf.lane      req1,
    dataReqIf.lane      req0
);

    stageState_e state;
    memOp_e      inOp [1:0];
    memSize_e    inSize [1:0];
    addr_t       inVaddr [1:0];
    word_t       inWdata [1:0];
    memOp_e      opQ [1:0];
    memSize_e    sizeQ [1:0];
    addr_t       vaddrQ [1:0];
    word_t       wdataQ [1:0];
    word_t       rdataQ [1:0];
    addr_t       paddr [1:0];
    word_t       alignedData [1:0];
    word_t       loadData [1:0];
    word_t       rdataIn [1:0];
    strobe_t     laneStrobe [1:0];
    logic [1:0]  signedQ, misaligned, fault, needMem, served, doneIn, laneWrite, reqValid;
    logic        accept, allDone;
    memOp_e      faultOp;

    assign inOp    = '{lane1Op, lane0Op};
    assign inSize  = '{lane1Size, lane0Size};
    assign inVaddr = '{lane1Vaddr, lane0Vaddr};
    assign inWdata = '{lane1Wdata, lane0Wdata};
    assign rdataIn = '{req1.rdata, req0.rdata};
    assign doneIn  = {req1.done, req0.done};

    assign accept = inValid && inReady;

    for (genvar i = 0; i < 2; i++) begin : gLane
        // pair register, loaded on accept
        always_ff @(posedge clk) begin
            if (accept) begin
                opQ[i]     <= inOp[i];
                sizeQ[i]   <= inSize[i];
                signedQ[i] <= (i == 1) ? lane1Signed : lane0Signed;
                vaddrQ[i]  <= inVaddr[i];
                wdataQ[i]  <= inWdata[i];
                rdataQ[i]  <= '0;
            end else if (doneIn[i] && opQ[i] == MEM_LOAD) begin
                rdataQ[i]  <= loadData[i];
            end
        end

        // kseg0/kseg1 drop the segment bits
        assign paddr[i] = (vaddrQ[i][31:30] == KSEG_TOP) ? {3'b000, vaddrQ[i][28:0]}
                                                          : vaddrQ[i];

        byteLaneAlign uAlign (
            .addrLow     (vaddrQ[i][1:0]),
            .size        (sizeQ[i]),
            .isSigned    (signedQ[i]),
            .storeData   (wdataQ[i]),
            .loadWord    (rdataIn[i]),
            .alignedData (alignedData[i]),
            .strobe      (laneStrobe[i]),
            .misaligned  (misaligned[i]),
            .loadData    (loadData[i])
        );

        assign fault[i]     = (opQ[i] != MEM_NONE) && misaligned[i];
        assign laneWrite[i] = (opQ[i] == MEM_STORE);
        assign reqValid[i]  = (state == ST_ISSUE) && needMem[i] && !served[i];
    end

    // older lane fault kills the younger one
    assign needMem[1] = (opQ[1] != MEM_NONE) && !misaligned[1];
    assign needMem[0] = (opQ[0] != MEM_NONE) && !misaligned[0] && !fault[1];
    assign allDone    = &(~needMem | served | doneIn);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ST_IDLE;
            served <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (inValid) begin
                        state  <= ST_ISSUE;
                        served <= '0;
                    end
                end
                ST_ISSUE: begin
                    served <= served | doneIn;
                    if (allDone) begin
                        state <= ST_DONE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign req1.valid  = reqValid[1];
    assign req1.write  = laneWrite[1];
    assign req1.paddr  = paddr[1];
    assign req1.wdata  = alignedData[1];
    assign req1.strobe = laneWrite[1] ? laneStrobe[1] : '0;
    assign req0.valid  = reqValid[0];
    assign req0.write  = laneWrite[0];
    assign req0.paddr  = paddr[0];
    assign req0.wdata  = alignedData[0];
    assign req0.strobe = laneWrite[0] ? laneStrobe[0] : '0;

    assign inReady    = (state == ST_IDLE);
    assign outValid   = (state == ST_DONE);
    assign lane1Rdata = rdataQ[1];
    assign lane0Rdata = rdataQ[0];

    // lane 1 takes precedence when reporting
    assign faultOp  = fault[1] ? opQ[1] : opQ[0];
    assign excValid = (state == ST_DONE) && (|fault);
    assign excLane  = fault[1];
    assign excCode  = (faultOp == MEM_STORE) ? EXC_ADES : EXC_ADEL;
    assign badVaddr = fault[1] ? vaddrQ[1] : vaddrQ[0];

    assert property (@(posedge clk) disable iff (reset)
        req1.valid && !req1.done |=>
            req1.valid && $stable({req1.write, req1.paddr, req1.wdata, req1.strobe}));
    assert property (@(posedge clk) disable iff (reset)
        req0.valid && !req0.done |=>
            req0.valid && $stable({req0.write, req0.paddr, req0.wdata, req0.strobe}));

    // a served lane drops its request in the next cycle
    assert property (@(posedge clk) disable iff (reset) req1.done |=> !req1.valid);
    assert property (@(posedge clk) disable iff (reset) req0.done |=> !req0.valid);

endmodule

//--- logic/apbArbiter.sv
`timescale 1ns/10ps

module apbArbiter
    import memPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    dataReqIf.arb   req1,
    dataReqIf.arb   req0,
    output logic    psel,
    output logic    penable,
    output logic    pwrite,
    output addr_t   paddr,
    output word_t   pwdata,
    output strobe_t pstrb,
    input  word_t   prdata,
    input  logic    pready
);

    apbState_e state;
    logic      grantLane1;
    logic      xferDone;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= APB_IDLE;
        end else begin
            case (state)
                APB_IDLE: begin
                    if (req1.valid || req0.valid) begin
                        state <= APB_SETUP;
                    end
                end
                APB_SETUP: state <= APB_ACCESS;
                APB_ACCESS: begin
                    if (pready) begin
                        state <= APB_IDLE;
                    end
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    // grant and transfer fields latched together, lane 1 first
    always_ff @(posedge clk) begin
        if (state == APB_IDLE) begin
            if (req1.valid) begin
                grantLane1 <= 1'b1;
                pwrite     <= req1.write;
                paddr      <= req1.paddr;
                pwdata     <= req1.wdata;
                pstrb      <= req1.strobe;
            end else if (req0.valid) begin
                grantLane1 <= 1'b0;
                pwrite     <= req0.write;
                paddr      <= req0.paddr;
                pwdata     <= req0.wdata;
                pstrb      <= req0.strobe;
            end
        end
    end

    assign psel     = (state != APB_IDLE);
    assign penable  = (state == APB_ACCESS);
    assign xferDone = penable && pready;

    // only the granted lane sees the completion
    assign req1.done  = xferDone && grantLane1;
    assign req0.done  = xferDone && !grantLane1;
    assign req1.rdata = grantLane1 ? prdata : '0;
    assign req0.rdata = grantLane1 ? '0 : prdata;

    // the granted lane keeps requesting the address under transfer
    assert property (@(posedge clk) disable iff (reset)
        psel |-> (grantLane1 ? (req1.valid && req1.paddr == paddr)
                             : (req0.valid && req0.paddr == paddr)));

endmodule

//--- logic/dataRam.sv
`timescale 1ns/10ps

module dataRam
    import memPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    psel,
    input  logic    penable,
    input  logic    pwrite,
    input  addr_t   paddr,
    input  word_t   pwdata,
    input  strobe_t pstrb,
    output word_t   prdata,
    output logic    pready
);

    word_t     mem [RAM_WORDS];
    ramIndex_t wordIndex;
    lfsr_t     lfsr;
    waitCnt_t  waitLeft;

    assign wordIndex = paddr[RAM_IDX_W+1:2];

    // x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // wait count drawn in the setup cycle, counted down in access
    always_ff @(posedge clk) begin
        if (reset) begin
            waitLeft <= '0;
        end else if (psel && !penable) begin
            waitLeft <= waitCnt_t'(lfsr % (RAM_MAX_WAIT + 1));
        end else if (penable && waitLeft != '0) begin
            waitLeft <= waitLeft - 1'b1;
        end
    end

    assign pready = penable && (waitLeft == '0);
    assign prdata = mem[wordIndex];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < RAM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (psel && pready && pwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb[b]) begin
                    mem[wordIndex][b*8 +: 8] <= pwdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- logic/memSubsystem.sv
`timescale 1ns/10ps

module memSubsystem
    import memPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     inValid,
    output logic     inReady,
    input  memOp_e   lane1Op,
    input  memSize_e lane1Size,
    input  logic     lane1Signed,
    input  addr_t    lane1Vaddr,
    input  word_t    lane1Wdata,
    input  memOp_e   lane0Op,
    input  memSize_e lane0Size,
    input  logic     lane0Signed,
    input  addr_t    lane0Vaddr,
    input  word_t    lane0Wdata,
    output logic     outValid,
    output word_t    lane1Rdata,
    output word_t    lane0Rdata,
    output logic     excValid,
    output logic     excLane,
    output excCode_e excCode,
    output addr_t    badVaddr
);

    logic    psel, penable, pwrite, pready;
    addr_t   paddr;
    word_t   pwdata, prdata;
    strobe_t pstrb;

    dataReqIf req1If ();
    dataReqIf req0If ();

    memStage i_memStage (
        .clk, .reset, .inValid, .inReady,
        .lane1Op, .lane1Size, .lane1Signed, .lane1Vaddr, .lane1Wdata,
        .lane0Op, .lane0Size, .lane0Signed, .lane0Vaddr, .lane0Wdata,
        .outValid, .lane1Rdata, .lane0Rdata,
        .excValid, .excLane, .excCode, .badVaddr,
        .req1 (req1If.lane),
        .req0 (req0If.lane)
    );

    apbArbiter i_apbArbiter (
        .clk, .reset,
        .req1 (req1If.arb),
        .req0 (req0If.arb),
        .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb, .prdata, .pready
    );

    dataRam i_dataRam (
        .clk, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb, .prdata, .pready
    );

endmodule

//--- test/memSubsystemTb.sv
`timescale 1ns/10ps

module memSubsystemTb
    import memPkg::*;
();

    localparam addr_t KSEG0_BASE   = 32'h8000_0000;
    localparam addr_t KSEG1_BASE   = 32'hA000_0000;
    localparam int    WAIT_LIMIT   = 50;
    localparam int    RANDOM_PAIRS = 400;

    logic     clk;
    logic     reset;
    logic     inValid;
    logic     inReady;
    memOp_e   lane1Op, lane0Op;
    memSize_e lane1Size, lane0Size;
    logic     lane1Signed, lane0Signed;
    addr_t    lane1Vaddr, lane0Vaddr;
    word_t    lane1Wdata, lane0Wdata;
    logic     outValid;
    word_t    lane1Rdata, lane0Rdata;
    logic     excValid;
    logic     excLane;
    excCode_e excCode;
    addr_t    badVaddr;

    // pair under test, index 1 is the older lane
    memOp_e   pOp [2];
    memSize_e pSize [2];
    logic     pSgn [2];
    addr_t    pVa [2];
    word_t    pWd [2];

    word_t modelMem [RAM_WORDS];
    int    mismatchCount = 0;
    int    timeoutCount = 0;
    int    handshakeCount = 0;
    int    pending = 0;

    memSubsystem i_memSubsystem (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // every accept must be answered by exactly one outValid cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (outValid) begin
                if (pending == 0) begin
                    handshakeCount++;
                    $display("outValid at %0t without an accepted pair", $time);
                end else begin
                    pending--;
                end
            end
            if (inValid && inReady) begin
                pending++;
            end
        end
    end

    function automatic addr_t physAddr(input addr_t va);
        // kseg0 is 3'b100 and kseg1 is 3'b101
        if (va[31:29] == 3'b100 || va[31:29] == 3'b101) begin
            return va & 32'h1FFF_FFFF;
        end
        return va;
    endfunction

    function automatic int sizeBytes(input memSize_e s);
        case (s)
            SIZE1:   return 1;
            SIZE2:   return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic isMisaligned(input addr_t va, input memSize_e s);
        return (va & addr_t'(sizeBytes(s) - 1)) != '0;
    endfunction

    task automatic applyLane(input int lane, output word_t rd);
        addr_t pa;
        int    idx, off, n, b;
        word_t w;
        rd  = '0;
        pa  = physAddr(pVa[lane]);
        idx = int'((pa >> 2) % addr_t'(RAM_WORDS));
        off = int'(pa[1:0]);
        n   = sizeBytes(pSize[lane]);
        w   = modelMem[idx];
        if (pOp[lane] == MEM_STORE) begin
            for (b = 0; b < n; b++) begin
                w[(off + b) * 8 +: 8] = pWd[lane][b * 8 +: 8];
            end
            modelMem[idx] = w;
        end else if (pOp[lane] == MEM_LOAD) begin
            for (b = 0; b < n; b++) begin
                rd[b * 8 +: 8] = w[(off + b) * 8 +: 8];
            end
            // sign fill above the loaded bytes
            if (pSgn[lane] && rd[n * 8 - 1]) begin
                for (b = n; b < 4; b++) begin
                    rd[b * 8 +: 8] = 8'hFF;
                end
            end
        end
    endtask

    task automatic checkWord(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic waitForReady(output logic ok);
        int n;
        n = 0;
        while (!inReady && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        ok = inReady;
        if (!ok) begin
            timeoutCount++;
            $display("timeout at %0t: inReady stayed low for %0d cycles", $time, WAIT_LIMIT);
        end
    endtask

    task automatic waitForOutValid(output logic ok);
        int n;
        n = 0;
        while (!outValid && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        ok = outValid;
        if (!ok) begin
            timeoutCount++;
            $display("timeout at %0t: no outValid within %0d cycles", $time, WAIT_LIMIT);
        end
    endtask

    task automatic setLane(input int lane, input memOp_e op, input memSize_e size,
                           input logic sgn, input addr_t va, input word_t wd);
        pOp[lane]   = op;
        pSize[lane] = size;
        pSgn[lane]  = sgn;
        pVa[lane]   = va;
        pWd[lane]   = wd;
    endtask

    task automatic pickRandomLane(input int lane, input int window);
        int       r, n, offset;
        memOp_e   op;
        memSize_e size;
        addr_t    base;
        r      = int'($urandom % 8);
        op     = (r == 0) ? MEM_NONE : ((r < 4) ? MEM_STORE : MEM_LOAD);
        size   = memSize_e'($urandom % 3);
        n      = sizeBytes(size);
        offset = int'($urandom % window);
        // mostly aligned, some faults
        if ($urandom % 8 != 0) begin
            offset = offset - (offset % n);
        end
        base = ($urandom % 2 == 0) ? KSEG0_BASE : KSEG1_BASE;
        setLane(lane, op, size, logic'($urandom % 2), base | addr_t'(offset), $urandom);
    endtask

    task automatic runPair();
        word_t    expRd [2];
        logic     expExc, expLane, ok;
        excCode_e expCode;
        addr_t    expBad;
        int       i;
        if (timeoutCount != 0) begin
            return;
        end
        expExc  = 1'b0;
        expLane = 1'b0;
        expCode = EXC_ADEL;
        expBad  = '0;
        expRd[0] = '0;
        expRd[1] = '0;
        // lane 1 first, its fault kills lane 0
        for (i = 1; i >= 0; i--) begin
            if (!expExc) begin
                if (pOp[i] != MEM_NONE && isMisaligned(pVa[i], pSize[i])) begin
                    expExc  = 1'b1;
                    expLane = (i == 1);
                    expCode = (pOp[i] == MEM_STORE) ? EXC_ADES : EXC_ADEL;
                    expBad  = pVa[i];
                end else begin
                    applyLane(i, expRd[i]);
                end
            end
        end
        waitForReady(ok);
        if (!ok) begin
            return;
        end
        lane1Op     = pOp[1];
        lane1Size   = pSize[1];
        lane1Signed = pSgn[1];
        lane1Vaddr  = pVa[1];
        lane1Wdata  = pWd[1];
        lane0Op     = pOp[0];
        lane0Size   = pSize[0];
        lane0Signed = pSgn[0];
        lane0Vaddr  = pVa[0];
        lane0Wdata  = pWd[0];
        inValid     = 1'b1;
        @(posedge clk);
        #1;
        inValid = 1'b0;
        waitForOutValid(ok);
        if (!ok) begin
            return;
        end
        checkWord("lane1Rdata", lane1Rdata, expRd[1]);
        checkWord("lane0Rdata", lane0Rdata, expRd[0]);
        checkWord("excValid", word_t'(excValid), word_t'(expExc));
        if (expExc) begin
            checkWord("excLane", word_t'(excLane), word_t'(expLane));
            checkWord("excCode", word_t'(excCode), word_t'(expCode));
            checkWord("badVaddr", badVaddr, expBad);
        end
    endtask

    initial begin
        int k;
        void'($urandom(32'h55261175));
        reset   = 1'b1;
        inValid = 1'b0;
        setLane(1, MEM_NONE, SIZE4, 1'b0, '0, '0);
        setLane(0, MEM_NONE, SIZE4, 1'b0, '0, '0);
        {lane1Op, lane1Size, lane1Signed, lane1Vaddr, lane1Wdata} = '0;
        {lane0Op, lane0Size, lane0Signed, lane0Vaddr, lane0Wdata} = '0;
        for (k = 0; k < RAM_WORDS; k++) begin
            modelMem[k] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        checkWord("inReady after reset", word_t'(inReady), 32'd1);
        checkWord("outValid after reset", word_t'(outValid), 32'd0);
        checkWord("excValid after reset", word_t'(excValid), 32'd0);

        // fill a small region, then loads of every size
        for (k = 0; k < 8; k++) begin
            setLane(1, MEM_STORE, SIZE4, 1'b0, KSEG0_BASE + addr_t'(k * 8), $urandom);
            setLane(0, MEM_STORE, SIZE4, 1'b0, KSEG1_BASE + addr_t'(k * 8 + 4), $urandom);
            runPair();
        end
        for (k = 0; k < 24; k++) begin
            setLane(1, MEM_LOAD, memSize_e'(k % 3), logic'((k / 3) % 2),
                    KSEG0_BASE + addr_t'((k * 4) % 64 + (k % 3 == 0 ? k % 4 : 0)), '0);
            setLane(0, MEM_LOAD, memSize_e'((k + 1) % 3), logic'((k / 6) % 2),
                    KSEG1_BASE + addr_t'((k * 12) % 64), '0);
            runPair();
        end

        // store then load inside one pair
        setLane(1, MEM_STORE, SIZE4, 1'b0, KSEG0_BASE + 32'h40, $urandom);
        setLane(0, MEM_LOAD, SIZE4, 1'b0, KSEG1_BASE + 32'h40, '0);
        runPair();
        setLane(1, MEM_STORE, SIZE1, 1'b0, KSEG1_BASE + 32'h43, 32'h0000_0080);
        setLane(0, MEM_LOAD, SIZE1, 1'b1, KSEG0_BASE + 32'h43, '0);
        runPair();

        // lane 1 faults and kills the lane 0 store
        setLane(1, MEM_LOAD, SIZE4, 1'b0, KSEG0_BASE + 32'h51, '0);
        setLane(0, MEM_STORE, SIZE4, 1'b0, KSEG0_BASE + 32'h60, 32'hDEAD_BEEF);
        runPair();
        setLane(1, MEM_STORE, SIZE2, 1'b0, KSEG1_BASE + 32'h63, 32'h1234);
        setLane(0, MEM_STORE, SIZE4, 1'b0, KSEG0_BASE + 32'h64, 32'hCAFE_F00D);
        runPair();
        setLane(1, MEM_LOAD, SIZE4, 1'b0, KSEG0_BASE + 32'h60, '0);
        setLane(0, MEM_LOAD, SIZE4, 1'b0, KSEG0_BASE + 32'h64, '0);
        runPair();

        // lane 0 faults alone
        setLane(1, MEM_STORE, SIZE4, 1'b0, KSEG0_BASE + 32'h70, 32'h8765_4321);
        setLane(0, MEM_LOAD, SIZE2, 1'b1, KSEG0_BASE + 32'h71, '0);
        runPair();
        setLane(1, MEM_LOAD, SIZE4, 1'b0, KSEG1_BASE + 32'h70, '0);
        setLane(0, MEM_STORE, SIZE2, 1'b0, KSEG1_BASE + 32'h77, 32'h5555);
        runPair();

        // kseg0 and kseg1 aliases
        setLane(1, MEM_STORE, SIZE4, 1'b0, KSEG1_BASE + 32'h80, $urandom);
        setLane(0, MEM_NONE, SIZE4, 1'b0, '0, '0);
        runPair();
        setLane(1, MEM_LOAD, SIZE4, 1'b0, KSEG0_BASE + 32'h80, '0);
        setLane(0, MEM_LOAD, SIZE4, 1'b0, KSEG1_BASE + 32'h80, '0);
        runPair();

        // random pairs, half of them in a narrow window for collisions
        for (k = 0; k < RANDOM_PAIRS; k++) begin
            pickRandomLane(1, (k % 2 == 0) ? 64 : RAM_WORDS * 4);
            pickRandomLane(0, (k % 2 == 0) ? 64 : RAM_WORDS * 4);
            runPair();
        end

        repeat (2) @(posedge clk);
        if (pending != 0) begin
            handshakeCount++;
            $display("%0d accepted pairs never produced outValid", pending);
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d handshake",
                 mismatchCount, timeoutCount, handshakeCount);
        if (mismatchCount + timeoutCount + handshakeCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- build.f
common/memPkg.sv
common/dataReqIf.sv
memStage/byteLaneAlign.sv
memStage/memStage.sv
logic/apbArbiter.sv
logic/dataRam.sv
logic/memSubsystem.sv
test/memSubsystemTb.sv

//--- Makefile
TOP = memSubsystemTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f build.f -Mdir obj_dir -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
